// ==== Bender.yml ====
package:
  name: etx

sources:
  - src/etx_pkg.sv
  - src/etx_fifo.sv
  - src/etx_arbiter.sv
  - src/etx_framer.sv
  - src/etx_top.sv
  - target: test
    files:
      - test/etx_props.sv
      - test/etx_tb.sv

// ==== files.f ====
src/etx_pkg.sv
src/etx_fifo.sv
src/etx_arbiter.sv
src/etx_framer.sv
src/etx_top.sv
test/etx_props.sv
test/etx_tb.sv

// ==== src/etx_arbiter.sv ====
// etx arbiter
// fixed priority over write, read request and read response fifos;
// pops one transaction and holds it for the framer until acknowledged
`timescale 1ns/1ps
`default_nettype none

module etx_arbiter (
  input  logic                        tx_lclk_div4,
  input  logic                        reset,
  // host writes
  input  logic                        emwr_fifo_access,
  input  logic [etx_pkg::dmode_w-1:0] emwr_fifo_datamode,
  input  logic [etx_pkg::cmode_w-1:0] emwr_fifo_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  emwr_fifo_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  emwr_fifo_data,
  input  logic [etx_pkg::addr_w-1:0]  emwr_fifo_srcaddr,
  // host read requests
  input  logic                        emrq_fifo_access,
  input  logic [etx_pkg::dmode_w-1:0] emrq_fifo_datamode,
  input  logic [etx_pkg::cmode_w-1:0] emrq_fifo_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  emrq_fifo_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  emrq_fifo_data,
  input  logic [etx_pkg::addr_w-1:0]  emrq_fifo_srcaddr,
  // read responses
  input  logic                        emrr_fifo_access,
  input  logic [etx_pkg::dmode_w-1:0] emrr_fifo_datamode,
  input  logic [etx_pkg::cmode_w-1:0] emrr_fifo_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  emrr_fifo_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  emrr_fifo_data,
  input  logic [etx_pkg::addr_w-1:0]  emrr_fifo_srcaddr,
  // link wait levels and framer ack
  input  logic                        etx_rd_wait,
  input  logic                        etx_wr_wait,
  input  logic                        etx_ack,
  output logic                        emwr_rd_en,
  output logic                        emrq_rd_en,
  output logic                        emrr_rd_en,
  output logic                        etx_access,
  output logic                        etx_write,
  output logic [etx_pkg::dmode_w-1:0] etx_datamode,
  output logic [etx_pkg::cmode_w-1:0] etx_ctrlmode,
  output logic [etx_pkg::addr_w-1:0]  etx_dstaddr,
  output logic [etx_pkg::addr_w-1:0]  etx_data,
  output logic [etx_pkg::addr_w-1:0]  etx_srcaddr
);
  import etx_pkg::*;

  // transaction currently held for the framer
  logic held;
  logic wr_ready;
  logic rq_ready;
  logic rr_ready;
  // free to take a new one
  logic can_pop;
  logic any_pop;

  // ##########################################################
  // priority masking
  // ##########################################################
  // writes highest
  assign wr_ready = emwr_fifo_access & ~etx_wr_wait;
  // read requests only stall on rd_wait
  assign rq_ready = emrq_fifo_access & ~etx_rd_wait & ~wr_ready;
  // responses lowest, share wr_wait with writes
  assign rr_ready = emrr_fifo_access & ~etx_wr_wait & ~wr_ready & ~rq_ready;

  // idle, or the framer is on its last byte
  assign can_pop = ~held | etx_ack;

  assign emwr_rd_en = wr_ready & can_pop;
  assign emrq_rd_en = rq_ready & can_pop;
  assign emrr_rd_en = rr_ready & can_pop;
  assign any_pop    = emwr_rd_en | emrq_rd_en | emrr_rd_en;

  // hold flag
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
      held <= 1'b0;
    else if (any_pop)
      held <= 1'b1;
    else if (etx_ack)
      held <= 1'b0;
  end

  assign etx_access = held;

  // ##########################################################
  // field capture on pop
  // ##########################################################
  // write bit is fixed per channel, fifo write field is not looked at
  always_ff @(posedge tx_lclk_div4)
  begin
    if (emwr_rd_en)
    begin
      etx_write    <= 1'b1;
      etx_datamode <= emwr_fifo_datamode;
      etx_ctrlmode <= emwr_fifo_ctrlmode;
      etx_dstaddr  <= emwr_fifo_dstaddr;
      etx_data     <= emwr_fifo_data;
      etx_srcaddr  <= emwr_fifo_srcaddr;
    end
    else if (emrq_rd_en)
    begin
      // read request goes out as a read
      etx_write    <= 1'b0;
      etx_datamode <= emrq_fifo_datamode;
      etx_ctrlmode <= emrq_fifo_ctrlmode;
      etx_dstaddr  <= emrq_fifo_dstaddr;
      etx_data     <= emrq_fifo_data;
      etx_srcaddr  <= emrq_fifo_srcaddr;
    end
    else if (emrr_rd_en)
    begin
      // response is a write back to the requester
      etx_write    <= 1'b1;
      etx_datamode <= emrr_fifo_datamode;
      etx_ctrlmode <= emrr_fifo_ctrlmode;
      etx_dstaddr  <= emrr_fifo_dstaddr;
      etx_data     <= emrr_fifo_data;
      etx_srcaddr  <= emrr_fifo_srcaddr;
    end
  end

endmodule

`default_nettype wire

// ==== src/etx_fifo.sv ====
// etx channel fifo
// single-clock show-ahead fifo holding one transaction channel
`timescale 1ns/1ps
`default_nettype none

module etx_fifo (
  input  logic                        tx_lclk_div4,
  input  logic                        reset,
  input  logic                        push,
  input  logic                        rd_en,
  input  logic                        in_write,
  input  logic [etx_pkg::dmode_w-1:0] in_datamode,
  input  logic [etx_pkg::cmode_w-1:0] in_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  in_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  in_data,
  input  logic [etx_pkg::addr_w-1:0]  in_srcaddr,
  output logic                        full,
  output logic                        fifo_access,
  output logic                        fifo_write,
  output logic [etx_pkg::dmode_w-1:0] fifo_datamode,
  output logic [etx_pkg::cmode_w-1:0] fifo_ctrlmode,
  output logic [etx_pkg::addr_w-1:0]  fifo_dstaddr,
  output logic [etx_pkg::addr_w-1:0]  fifo_data,
  output logic [etx_pkg::addr_w-1:0]  fifo_srcaddr
);
  import etx_pkg::*;

  // entry storage, one array per field
  logic                  mem_write    [fifo_depth];
  logic [dmode_w-1:0]    mem_datamode [fifo_depth];
  logic [cmode_w-1:0]    mem_ctrlmode [fifo_depth];
  logic [addr_w-1:0]     mem_dstaddr  [fifo_depth];
  logic [addr_w-1:0]     mem_data     [fifo_depth];
  logic [addr_w-1:0]     mem_srcaddr  [fifo_depth];

  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  // occupancy, one bit wider than the pointers
  logic [fifo_ptr_w:0]   count;
  logic                  do_push;
  logic                  do_pop;

  // push while full is dropped
  assign do_push = push & ~full;
  // pop only when something is there
  assign do_pop  = rd_en & fifo_access;

  assign full        = (count == (fifo_ptr_w + 1)'(fifo_depth));
  assign fifo_access = (count != '0);

  // pointers and occupancy
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // push and pop together leave count alone
      if (do_push & ~do_pop)
        count <= count + 1'b1;
      else if (do_pop & ~do_push)
        count <= count - 1'b1;
    end
  end

  // entry write
  always_ff @(posedge tx_lclk_div4)
  begin
    if (do_push)
    begin
      mem_write[wr_ptr]    <= in_write;
      mem_datamode[wr_ptr] <= in_datamode;
      mem_ctrlmode[wr_ptr] <= in_ctrlmode;
      mem_dstaddr[wr_ptr]  <= in_dstaddr;
      mem_data[wr_ptr]     <= in_data;
      mem_srcaddr[wr_ptr]  <= in_srcaddr;
    end
  end

  // show-ahead head, arbiter sees it before popping
  assign fifo_write    = mem_write[rd_ptr];
  assign fifo_datamode = mem_datamode[rd_ptr];
  assign fifo_ctrlmode = mem_ctrlmode[rd_ptr];
  assign fifo_dstaddr  = mem_dstaddr[rd_ptr];
  assign fifo_data     = mem_data[rd_ptr];
  assign fifo_srcaddr  = mem_srcaddr[rd_ptr];

endmodule

`default_nettype wire

// ==== src/etx_framer.sv ====
// etx framer
// sends the held transaction as a 13-byte frame, acks on the last byte
`timescale 1ns/1ps
`default_nettype none

module etx_framer (
  input  logic                        tx_lclk_div4,
  input  logic                        reset,
  input  logic                        etx_access,
  input  logic                        etx_write,
  input  logic [etx_pkg::dmode_w-1:0] etx_datamode,
  input  logic [etx_pkg::cmode_w-1:0] etx_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  etx_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  etx_data,
  input  logic [etx_pkg::addr_w-1:0]  etx_srcaddr,
  output logic                        etx_ack,
  output logic                        tx_frame,
  output logic [7:0]                  tx_byte
);
  import etx_pkg::*;

  etx_state_e             state;
  logic [frame_cnt_w-1:0] byte_cnt;
  logic [7:0]             byte_sel;
  logic                   last_byte;

  assign last_byte = (byte_cnt == frame_cnt_w'(frame_bytes - 1));

  // ##########################################################
  // byte select, package frame order
  // ##########################################################
  always_comb
  begin
    case (byte_cnt)
      // control byte, bit 0 reserved
      4'd0:    byte_sel = {etx_write, etx_datamode, etx_ctrlmode, 1'b0};
      4'd1:    byte_sel = etx_dstaddr[31:24];
      4'd2:    byte_sel = etx_dstaddr[23:16];
      4'd3:    byte_sel = etx_dstaddr[15:8];
      4'd4:    byte_sel = etx_dstaddr[7:0];
      4'd5:    byte_sel = etx_data[31:24];
      4'd6:    byte_sel = etx_data[23:16];
      4'd7:    byte_sel = etx_data[15:8];
      4'd8:    byte_sel = etx_data[7:0];
      4'd9:    byte_sel = etx_srcaddr[31:24];
      4'd10:   byte_sel = etx_srcaddr[23:16];
      4'd11:   byte_sel = etx_srcaddr[15:8];
      4'd12:   byte_sel = etx_srcaddr[7:0];
      default: byte_sel = 8'h00;
    endcase
  end

  // ##########################################################
  // frame fsm
  // ##########################################################
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      state    <= st_idle;
      byte_cnt <= '0;
      tx_frame <= 1'b0;
      tx_byte  <= 8'h00;
      etx_ack  <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          tx_frame <= 1'b0;
          tx_byte  <= 8'h00;
          etx_ack  <= 1'b0;
          byte_cnt <= '0;
          // access in the ack cycle is still the old transaction
          if (etx_access & ~etx_ack)
            state <= st_send;
        end
        st_send:
        begin
          tx_frame <= 1'b1;
          tx_byte  <= byte_sel;
          // ack lines up with byte 12
          etx_ack  <= last_byte;
          byte_cnt <= byte_cnt + 1'b1;
          if (last_byte)
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/etx_pkg.sv ====
// etx package
// shared field widths, frame layout, channel FIFO depth and framer state
`default_nettype none

package etx_pkg;

  // ##########################################################
  // transaction field widths
  // ##########################################################
  localparam int addr_w  = 32;
  localparam int dmode_w = 2;
  localparam int cmode_w = 4;

  // ##########################################################
  // frame layout
  // ##########################################################
  // byte 0     control: write[7], datamode[6:5], ctrlmode[4:1], bit 0 zero
  // bytes 1-4  dstaddr, msb first
  // bytes 5-8  data, msb first
  // bytes 9-12 srcaddr, msb first
  localparam int frame_bytes = 13;
  // byte counter width for the framer
  localparam int frame_cnt_w = $clog2(frame_bytes);

  // channel fifo sizing, shared by all three channels
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = 2;

  // framer states
  typedef enum logic {
    st_idle,
    st_send
  } etx_state_e;

endpackage

`default_nettype wire

// ==== src/etx_top.sv ====
// etx top
// mesh link transmit side: three channel fifos, arbiter and framer
`timescale 1ns/1ps
`default_nettype none

module etx_top (
  input  logic                        tx_lclk_div4,
  input  logic                        reset,
  input  logic                        rd_wait,
  input  logic                        wr_wait,
  // host writes
  input  logic                        wr_push,
  input  logic                        wr_write,
  input  logic [etx_pkg::dmode_w-1:0] wr_datamode,
  input  logic [etx_pkg::cmode_w-1:0] wr_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  wr_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  wr_data,
  input  logic [etx_pkg::addr_w-1:0]  wr_srcaddr,
  output logic                        wr_full,
  // host read requests
  input  logic                        rq_push,
  input  logic                        rq_write,
  input  logic [etx_pkg::dmode_w-1:0] rq_datamode,
  input  logic [etx_pkg::cmode_w-1:0] rq_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  rq_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  rq_data,
  input  logic [etx_pkg::addr_w-1:0]  rq_srcaddr,
  output logic                        rq_full,
  // read responses
  input  logic                        rr_push,
  input  logic                        rr_write,
  input  logic [etx_pkg::dmode_w-1:0] rr_datamode,
  input  logic [etx_pkg::cmode_w-1:0] rr_ctrlmode,
  input  logic [etx_pkg::addr_w-1:0]  rr_dstaddr,
  input  logic [etx_pkg::addr_w-1:0]  rr_data,
  input  logic [etx_pkg::addr_w-1:0]  rr_srcaddr,
  output logic                        rr_full,
  // byte stream
  output logic                        tx_frame,
  output logic [7:0]                  tx_byte
);
  import etx_pkg::*;

  // fifo heads
  logic               wr_fifo_access;
  logic [dmode_w-1:0] wr_fifo_datamode;
  logic [cmode_w-1:0] wr_fifo_ctrlmode;
  logic [addr_w-1:0]  wr_fifo_dstaddr;
  logic [addr_w-1:0]  wr_fifo_data;
  logic [addr_w-1:0]  wr_fifo_srcaddr;
  logic               rq_fifo_access;
  logic [dmode_w-1:0] rq_fifo_datamode;
  logic [cmode_w-1:0] rq_fifo_ctrlmode;
  logic [addr_w-1:0]  rq_fifo_dstaddr;
  logic [addr_w-1:0]  rq_fifo_data;
  logic [addr_w-1:0]  rq_fifo_srcaddr;
  logic               rr_fifo_access;
  logic [dmode_w-1:0] rr_fifo_datamode;
  logic [cmode_w-1:0] rr_fifo_ctrlmode;
  logic [addr_w-1:0]  rr_fifo_dstaddr;
  logic [addr_w-1:0]  rr_fifo_data;
  logic [addr_w-1:0]  rr_fifo_srcaddr;
  // pops
  logic               wr_rd_en;
  logic               rq_rd_en;
  logic               rr_rd_en;
  // held transaction
  logic               etx_access;
  logic               etx_write;
  logic [dmode_w-1:0] etx_datamode;
  logic [cmode_w-1:0] etx_ctrlmode;
  logic [addr_w-1:0]  etx_dstaddr;
  logic [addr_w-1:0]  etx_data;
  logic [addr_w-1:0]  etx_srcaddr;
  logic               etx_ack;

  // write bit per channel is set by the arbiter, head write bits stay open
  etx_fifo u_wr_fifo (
    .tx_lclk_div4 (tx_lclk_div4), .reset (reset), .push (wr_push), .rd_en (wr_rd_en),
    .in_write (wr_write), .in_datamode (wr_datamode), .in_ctrlmode (wr_ctrlmode),
    .in_dstaddr (wr_dstaddr), .in_data (wr_data), .in_srcaddr (wr_srcaddr),
    .full (wr_full), .fifo_access (wr_fifo_access), .fifo_write (),
    .fifo_datamode (wr_fifo_datamode), .fifo_ctrlmode (wr_fifo_ctrlmode),
    .fifo_dstaddr (wr_fifo_dstaddr), .fifo_data (wr_fifo_data),
    .fifo_srcaddr (wr_fifo_srcaddr)
  );

  etx_fifo u_rq_fifo (
    .tx_lclk_div4 (tx_lclk_div4), .reset (reset), .push (rq_push), .rd_en (rq_rd_en),
    .in_write (rq_write), .in_datamode (rq_datamode), .in_ctrlmode (rq_ctrlmode),
    .in_dstaddr (rq_dstaddr), .in_data (rq_data), .in_srcaddr (rq_srcaddr),
    .full (rq_full), .fifo_access (rq_fifo_access), .fifo_write (),
    .fifo_datamode (rq_fifo_datamode), .fifo_ctrlmode (rq_fifo_ctrlmode),
    .fifo_dstaddr (rq_fifo_dstaddr), .fifo_data (rq_fifo_data),
    .fifo_srcaddr (rq_fifo_srcaddr)
  );

  etx_fifo u_rr_fifo (
    .tx_lclk_div4 (tx_lclk_div4), .reset (reset), .push (rr_push), .rd_en (rr_rd_en),
    .in_write (rr_write), .in_datamode (rr_datamode), .in_ctrlmode (rr_ctrlmode),
    .in_dstaddr (rr_dstaddr), .in_data (rr_data), .in_srcaddr (rr_srcaddr),
    .full (rr_full), .fifo_access (rr_fifo_access), .fifo_write (),
    .fifo_datamode (rr_fifo_datamode), .fifo_ctrlmode (rr_fifo_ctrlmode),
    .fifo_dstaddr (rr_fifo_dstaddr), .fifo_data (rr_fifo_data),
    .fifo_srcaddr (rr_fifo_srcaddr)
  );

  etx_arbiter u_arbiter (
    .tx_lclk_div4 (tx_lclk_div4), .reset (reset),
    .emwr_fifo_access (wr_fifo_access), .emwr_fifo_datamode (wr_fifo_datamode),
    .emwr_fifo_ctrlmode (wr_fifo_ctrlmode), .emwr_fifo_dstaddr (wr_fifo_dstaddr),
    .emwr_fifo_data (wr_fifo_data), .emwr_fifo_srcaddr (wr_fifo_srcaddr),
    .emrq_fifo_access (rq_fifo_access), .emrq_fifo_datamode (rq_fifo_datamode),
    .emrq_fifo_ctrlmode (rq_fifo_ctrlmode), .emrq_fifo_dstaddr (rq_fifo_dstaddr),
    .emrq_fifo_data (rq_fifo_data), .emrq_fifo_srcaddr (rq_fifo_srcaddr),
    .emrr_fifo_access (rr_fifo_access), .emrr_fifo_datamode (rr_fifo_datamode),
    .emrr_fifo_ctrlmode (rr_fifo_ctrlmode), .emrr_fifo_dstaddr (rr_fifo_dstaddr),
    .emrr_fifo_data (rr_fifo_data), .emrr_fifo_srcaddr (rr_fifo_srcaddr),
    .etx_rd_wait (rd_wait), .etx_wr_wait (wr_wait), .etx_ack (etx_ack),
    .emwr_rd_en (wr_rd_en), .emrq_rd_en (rq_rd_en), .emrr_rd_en (rr_rd_en),
    .etx_access (etx_access), .etx_write (etx_write), .etx_datamode (etx_datamode),
    .etx_ctrlmode (etx_ctrlmode), .etx_dstaddr (etx_dstaddr), .etx_data (etx_data),
    .etx_srcaddr (etx_srcaddr)
  );

  etx_framer u_framer (
    .tx_lclk_div4 (tx_lclk_div4), .reset (reset),
    .etx_access (etx_access), .etx_write (etx_write), .etx_datamode (etx_datamode),
    .etx_ctrlmode (etx_ctrlmode), .etx_dstaddr (etx_dstaddr), .etx_data (etx_data),
    .etx_srcaddr (etx_srcaddr),
    .etx_ack (etx_ack), .tx_frame (tx_frame), .tx_byte (tx_byte)
  );

endmodule

`default_nettype wire

// ==== test/etx_props.sv ====
// etx properties
// pop, hold and frame length rules, bound into the arbiter and the framer
`timescale 1ns/1ps
`default_nettype none

module etx_props (
  input logic                                                             tx_lclk_div4,
  input logic                                                             reset,
  input logic [2:0]                                                       rd_en,
  input logic                                                             access,
  input logic                                                             ack,
  input logic [3*etx_pkg::addr_w+etx_pkg::cmode_w+etx_pkg::dmode_w:0]     fields,
  input logic                                                             tx_frame
);
  import etx_pkg::*;

  // one channel popped per cycle at most
  a_one_pop: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    $onehot0(rd_en))
    else $error("more than one channel fifo popped in one cycle");

  a_ack_held: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    ack |-> access)
    else $error("ack without a held transaction");

  // held fields frozen until the ack cycle
  a_fields_stable: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    (access && !ack) |=> $stable(fields))
    else $error("held transaction changed before ack");

  a_frame_len: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    $rose(tx_frame) |-> tx_frame [*frame_bytes] ##1 !tx_frame)
    else $error("tx_frame not high for exactly one frame");

endmodule

// arbiter side, no byte stream here
bind etx_arbiter etx_props u_arb_props (
  .tx_lclk_div4 (tx_lclk_div4), .reset (reset),
  .rd_en ({emwr_rd_en, emrq_rd_en, emrr_rd_en}),
  .access (etx_access), .ack (etx_ack),
  .fields ({etx_write, etx_datamode, etx_ctrlmode, etx_dstaddr, etx_data, etx_srcaddr}),
  .tx_frame (1'b0)
);

// framer side, no pops here
bind etx_framer etx_props u_framer_props (
  .tx_lclk_div4 (tx_lclk_div4), .reset (reset),
  .rd_en (3'b000),
  .access (etx_access), .ack (etx_ack),
  .fields ({etx_write, etx_datamode, etx_ctrlmode, etx_dstaddr, etx_data, etx_srcaddr}),
  .tx_frame (tx_frame)
);

`default_nettype wire

// ==== test/etx_tb.sv ====
// etx testbench
// pushes traffic into the three channel fifos and checks every frame
// against a reference packing of the pushed transaction
`timescale 1ns/1ps
`default_nettype none

module etx_tb;
  import etx_pkg::*;

  logic                     tx_lclk_div4;
  logic                     reset;
  logic                     rd_wait;
  logic                     wr_wait;
  logic                     wr_push, rq_push, rr_push;
  logic                     wr_write, rq_write, rr_write;
  logic [dmode_w-1:0]       wr_datamode, rq_datamode, rr_datamode;
  logic [cmode_w-1:0]       wr_ctrlmode, rq_ctrlmode, rr_ctrlmode;
  logic [addr_w-1:0]        wr_dstaddr, rq_dstaddr, rr_dstaddr;
  logic [addr_w-1:0]        wr_data, rq_data, rr_data;
  logic [addr_w-1:0]        wr_srcaddr, rq_srcaddr, rr_srcaddr;
  logic                     wr_full, rq_full, rr_full;
  logic                     tx_frame;
  logic [7:0]               tx_byte;

  // expected frames per channel in wr rq rr index order
  logic [frame_bytes*8-1:0] exp_q [3][$];
  // captured frames waiting for compare
  logic [frame_bytes*8-1:0] got_q [$];
  logic [frame_bytes*8-1:0] last_frame [3];
  logic [frame_bytes*8-1:0] cap_buf;
  // channel of each frame in arrival order
  int                       tag_log [$];
  int                       cap_cnt = 0;
  int                       frames_seen = 0;
  int                       pushed_total = 0;
  int                       n_random = 40;
  integer                   seed = 32'h7c09a073;

  etx_top i_etx_top (.*);

  // 40 ns period
  initial tx_lclk_div4 = 1'b0;
  always #20 tx_lclk_div4 = ~tx_lclk_div4;

  // ##########################################################
  // reference model and helpers
  // ##########################################################
  // control byte then dstaddr data and srcaddr msb first
  function automatic logic [frame_bytes*8-1:0] expected_frame(
    input logic               write,
    input logic [dmode_w-1:0] dmode,
    input logic [cmode_w-1:0] cmode,
    input logic [addr_w-1:0]  dst,
    input logic [addr_w-1:0]  data,
    input logic [addr_w-1:0]  src
  );
    logic [7:0] ctrl;
    ctrl = {write, dmode, cmode, 1'b0};
    return {ctrl, dst, data, src};
  endfunction

  // dstaddr[31:30] of byte 1
  function automatic int channel_tag(input logic [frame_bytes*8-1:0] frame);
    return int'(frame[(frame_bytes-1)*8-1 -: 2]);
  endfunction

  function automatic logic channel_full(input int ch);
    case (ch)
      0:       return wr_full;
      1:       return rq_full;
      default: return rr_full;
    endcase
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [frame_bytes*8-1:0] got,
                             input logic [frame_bytes*8-1:0] exp);
    if (got !== exp)
      fail_now($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // inputs move 2 ns after the edge and pushes last one cycle
  task automatic next_cycle();
    @(posedge tx_lclk_div4);
    #2;
    wr_push = 1'b0;
    rq_push = 1'b0;
    rr_push = 1'b0;
  endtask

  // random fields with the channel number in dstaddr[31:30]
  task automatic push_txn(input int ch, input logic write_in);
    logic [dmode_w-1:0] dmode;
    logic [cmode_w-1:0] cmode;
    logic [addr_w-1:0]  dst;
    logic [addr_w-1:0]  data;
    logic [addr_w-1:0]  src;
    logic               framed_write;
    dmode = dmode_w'($random(seed));
    cmode = cmode_w'($random(seed));
    dst   = $random(seed);
    data  = $random(seed);
    src   = $random(seed);
    dst[addr_w-1 -: 2] = ch[1:0];
    // read requests leave as reads and the rest as writes
    framed_write = (ch != 1);
    if (channel_full(ch))
      fail_now($sformatf("push attempted on full fifo of channel %0d", ch));
    case (ch)
      0:
      begin
        wr_push     = 1'b1;
        wr_write    = write_in;
        wr_datamode = dmode;
        wr_ctrlmode = cmode;
        wr_dstaddr  = dst;
        wr_data     = data;
        wr_srcaddr  = src;
      end
      1:
      begin
        rq_push     = 1'b1;
        rq_write    = write_in;
        rq_datamode = dmode;
        rq_ctrlmode = cmode;
        rq_dstaddr  = dst;
        rq_data     = data;
        rq_srcaddr  = src;
      end
      default:
      begin
        rr_push     = 1'b1;
        rr_write    = write_in;
        rr_datamode = dmode;
        rr_ctrlmode = cmode;
        rr_dstaddr  = dst;
        rr_data     = data;
        rr_srcaddr  = src;
      end
    endcase
    exp_q[ch].push_back(expected_frame(framed_write, dmode, cmode, dst, data, src));
    pushed_total++;
  endtask

  // about 20 cycles per outstanding frame
  task automatic wait_frames(input int target);
    int budget;
    budget = 20 * (target - frames_seen) + 100;
    while (frames_seen < target && budget > 0)
    begin
      next_cycle();
      budget--;
    end
    if (frames_seen < target)
      fail_now($sformatf("timed out waiting for %0d frames, saw %0d", target, frames_seen));
  endtask

  // ##########################################################
  // frame capture and compare
  // ##########################################################
  // sampled on the falling edge away from output updates
  always @(negedge tx_lclk_div4)
  begin : capture_frame
    if (reset)
      cap_cnt = 0;
    else if (tx_frame)
    begin
      if (cap_cnt == frame_bytes)
        fail_now("tx_frame stayed high longer than one frame");
      cap_buf = {cap_buf[(frame_bytes-1)*8-1:0], tx_byte};
      cap_cnt++;
      if (cap_cnt == frame_bytes)
        got_q.push_back(cap_buf);
    end
    else
    begin
      if (cap_cnt != 0 && cap_cnt != frame_bytes)
        fail_now($sformatf("tx_frame dropped after %0d bytes", cap_cnt));
      cap_cnt = 0;
    end
  end

  always @(posedge tx_lclk_div4)
  begin : compare_frame
    logic [frame_bytes*8-1:0] got;
    int                       ch;
    if (got_q.size() != 0)
    begin
      got = got_q.pop_front();
      ch  = channel_tag(got);
      if (ch > 2)
        fail_now("frame carries an unknown channel tag");
      else if (exp_q[ch].size() == 0)
        fail_now($sformatf("frame on channel %0d with nothing queued", ch));
      else
      begin
        check_value($sformatf("frame ch%0d", ch), got, exp_q[ch].pop_front());
        last_frame[ch] = got;
        tag_log.push_back(ch);
        frames_seen++;
      end
    end
  end

  // whole run at 20 cycles per transaction plus margin
  initial
  begin : watchdog
    repeat (20 * (1 + 2 + 3 * fifo_depth + 7 + n_random) + 1000) @(posedge tx_lclk_div4);
    fail_now("watchdog expired, run took too long");
  end

  // ##########################################################
  // test sequence
  // ##########################################################
  initial
  begin : main
    int start;
    int base;
    int n;
    int ch;
    int drain_order [7];
    // requests drain before the held writes and responses
    drain_order = '{1, 1, 1, 0, 0, 2, 2};
    reset    = 1'b1;
    rd_wait  = 1'b0;
    wr_wait  = 1'b0;
    wr_push  = 1'b0;
    rq_push  = 1'b0;
    rr_push  = 1'b0;
    wr_write = 1'b0;
    rq_write = 1'b0;
    rr_write = 1'b0;
    {wr_datamode, rq_datamode, rr_datamode} = '0;
    {wr_ctrlmode, rq_ctrlmode, rr_ctrlmode} = '0;
    {wr_dstaddr, rq_dstaddr, rr_dstaddr}    = '0;
    {wr_data, rq_data, rr_data}             = '0;
    {wr_srcaddr, rq_srcaddr, rr_srcaddr}    = '0;
    repeat (5) @(posedge tx_lclk_div4);
    #2;
    reset = 1'b0;
    next_cycle();

    // outputs quiet after reset
    check_value("tx_frame", tx_frame, 0);
    check_value("tx_byte", tx_byte, 0);
    check_value("wr_full", wr_full, 0);
    check_value("rq_full", rq_full, 0);
    check_value("rr_full", rr_full, 0);

    // single write
    push_txn(0, 1'b1);
    next_cycle();
    wait_frames(pushed_total);
    check_value("write ctrl bit 7", last_frame[0][frame_bytes*8-1], 1);

    // write bit forced by channel
    push_txn(1, 1'b1);
    next_cycle();
    wait_frames(pushed_total);
    check_value("read request ctrl bit 7", last_frame[1][frame_bytes*8-1], 0);
    push_txn(2, 1'b0);
    next_cycle();
    wait_frames(pushed_total);
    check_value("read response ctrl bit 7", last_frame[2][frame_bytes*8-1], 1);

    // priority with everything filled behind both waits
    rd_wait = 1'b1;
    wr_wait = 1'b1;
    for (int i = 0; i < fifo_depth; i++)
    begin
      push_txn(0, 1'($random(seed)));
      push_txn(1, 1'($random(seed)));
      push_txn(2, 1'($random(seed)));
      next_cycle();
    end
    check_value("wr_full", wr_full, 1);
    check_value("rq_full", rq_full, 1);
    check_value("rr_full", rr_full, 1);
    start   = tag_log.size();
    rd_wait = 1'b0;
    wr_wait = 1'b0;
    wait_frames(pushed_total);
    for (int k = 0; k < 3 * fifo_depth; k++)
      check_value("priority order channel", tag_log[start + k], k / fifo_depth);

    // wr_wait holds writes and responses while requests pass
    wr_wait = 1'b1;
    start   = tag_log.size();
    base    = frames_seen;
    for (int i = 0; i < 2; i++)
    begin
      push_txn(0, 1'b1);
      push_txn(2, 1'b1);
      next_cycle();
    end
    for (int i = 0; i < 3; i++)
    begin
      push_txn(1, 1'b0);
      next_cycle();
    end
    wait_frames(base + 3);
    repeat (40) next_cycle();
    check_value("frames under wr_wait", frames_seen, base + 3);
    wr_wait = 1'b0;
    wait_frames(pushed_total);
    for (int k = 0; k < 7; k++)
      check_value("wr_wait order channel", tag_log[start + k], drain_order[k]);

    // random traffic with wait toggling
    n = 0;
    while (n < n_random)
    begin
      rd_wait = (($random(seed) & 3) == 0);
      wr_wait = (($random(seed) & 3) == 0);
      ch      = $unsigned($random(seed)) % 3;
      if (!channel_full(ch) && ($random(seed) & 1))
      begin
        push_txn(ch, 1'($random(seed)));
        n++;
      end
      next_cycle();
    end
    rd_wait = 1'b0;
    wr_wait = 1'b0;
    wait_frames(pushed_total);
    next_cycle();

    if (got_q.size() == 0 && exp_q[0].size() == 0 && exp_q[1].size() == 0 &&
        exp_q[2].size() == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
      fail_now("expected or captured frames left over at the end");
  end

endmodule

`default_nettype wire
